/* hw/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

    // Data path width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes handled by the slice
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // Shared funct3 codes of OP and OP-IMM
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    typedef enum logic [2:0] {
        cls_reg   = 3'd0,
        cls_imm   = 3'd1,
        cls_mem   = 3'd2,
        cls_lui   = 3'd3,
        cls_auipc = 3'd4,
        cls_none  = 3'd7
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // Everything the later stages need from one instruction word
    typedef struct packed {
        op_class_e op_class;
        alu_op_e   alu_op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic [4:0] shamt;
        xlen_t     imm_i;
        xlen_t     imm_u;
        logic      wb_en;
    } decoded_t;

    // The two ALU inputs
    typedef struct packed {
        xlen_t data0;
        xlen_t data1;
    } operands_t;

endpackage

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  rv_exec_pkg::xlen_t    instr,
    output rv_exec_pkg::decoded_t dec
);

    import rv_exec_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alt;
    logic [11:0] imm12;
    op_class_e   op_class;
    alu_op_e     alu_op;

    // Fixed RV32I field positions
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // Bit 30 tells SUB from ADD and SRA from SRL
    assign alt    = instr[30];

    // Opcode class
    always_comb begin
        case (opcode)
            opc_op:     op_class = cls_reg;
            opc_op_imm: op_class = cls_imm;
            opc_load:   op_class = cls_mem;
            opc_store:  op_class = cls_mem;
            opc_lui:    op_class = cls_lui;
            opc_auipc:  op_class = cls_auipc;
            default:    op_class = cls_none;
        endcase
    end

    // Stores split their offset around the rd field
    assign imm12 = (opcode == opc_store) ? {instr[31:25], instr[11:7]} : instr[31:20];

    // Only OP and OP-IMM take the ALU operation from funct3
    always_comb begin
        alu_op = alu_add;
        if (op_class == cls_reg || op_class == cls_imm) begin
            case (funct3)
                // No SUBI, so bit 30 only counts for OP
                f3_add:  alu_op = (alt && op_class == cls_reg) ? alu_sub : alu_add;
                f3_sll:  alu_op = alu_sll;
                f3_slt:  alu_op = alu_slt;
                f3_sltu: alu_op = alu_sltu;
                f3_xor:  alu_op = alu_xor;
                f3_srl:  alu_op = alt ? alu_sra : alu_srl;
                f3_or:   alu_op = alu_or;
                f3_and:  alu_op = alu_and;
                default: alu_op = alu_add;
            endcase
        end
    end

    always_comb begin
        dec.op_class = op_class;
        dec.alu_op   = alu_op;
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rd       = instr[11:7];
        // Shift amount sits in the rs2 slot for OP-IMM shifts
        dec.shamt    = instr[24:20];
        dec.imm_i    = {{(xlen-12){imm12[11]}}, imm12};
        dec.imm_u    = {instr[31:12], 12'b0};
        // Loads and stores only show their address
        dec.wb_en    = (op_class == cls_reg) || (op_class == cls_imm) ||
                       (op_class == cls_lui) || (op_class == cls_auipc);
    end

endmodule

`default_nettype wire

/* hw/operand_select.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_select (
    input  rv_exec_pkg::decoded_t  dec,
    input  rv_exec_pkg::xlen_t     rs1_data,
    input  rv_exec_pkg::xlen_t     rs2_data,
    input  rv_exec_pkg::xlen_t     pc,
    output rv_exec_pkg::operands_t ops
);

    import rv_exec_pkg::*;

    logic  is_lui;
    logic  is_auipc;
    logic  is_upper;
    logic  imm_shift;
    xlen_t shamt_ext;
    xlen_t imm_val;
    xlen_t upper_base;

    assign is_lui   = (dec.op_class == cls_lui);
    assign is_auipc = (dec.op_class == cls_auipc);
    assign is_upper = is_lui | is_auipc;

    // Shift by immediate, covers SLLI, SRLI and SRAI
    // Memory ops keep their offset whatever funct3 holds
    assign imm_shift = (dec.op_class == cls_imm) &&
                       ((dec.alu_op == alu_sll) ||
                        (dec.alu_op == alu_srl) ||
                        (dec.alu_op == alu_sra));

    assign shamt_ext = {{(xlen-5){1'b0}}, dec.shamt};

    // Upper immediate for LUI/AUIPC, else the 12-bit one
    assign imm_val = is_upper ? dec.imm_u : dec.imm_i;

    // LUI adds to zero, AUIPC to the PC
    assign upper_base = is_auipc ? pc : '0;

    always_comb begin
        ops.data0 = is_upper ? upper_base : rs1_data;

        if (dec.op_class == cls_reg) begin
            ops.data1 = rs2_data;
        end else if (imm_shift) begin
            ops.data1 = shamt_ext;
        end else begin
            ops.data1 = imm_val;
        end
    end

endmodule

`default_nettype wire

/* hw/int_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module int_alu (
    input  rv_exec_pkg::operands_t ops,
    input  rv_exec_pkg::alu_op_e   alu_op,
    output rv_exec_pkg::xlen_t     alu_result
);

    import rv_exec_pkg::*;

    xlen_t      a;
    xlen_t      b;
    logic [4:0] sh;
    logic       lt_signed;
    logic       lt_unsigned;
    xlen_t      sum;
    xlen_t      diff;

    assign a  = ops.data0;
    assign b  = ops.data1;

    // RV32I only looks at the low five bits for shifts
    assign sh = b[4:0];

    assign sum  = a + b;
    assign diff = a - b;

    // Compare results for SLT and SLTU
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (alu_op)
            alu_add: begin
                alu_result = sum;
            end
            alu_sub: begin
                alu_result = diff;
            end
            alu_sll: begin
                alu_result = a << sh;
            end
            alu_slt: begin
                alu_result = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                alu_result = a ^ b;
            end
            alu_srl: begin
                alu_result = a >> sh;
            end
            alu_sra: begin
                // Arithmetic shift keeps the sign bit
                alu_result = xlen_t'($signed(a) >>> sh);
            end
            alu_or: begin
                alu_result = a | b;
            end
            alu_and: begin
                alu_result = a & b;
            end
            default: begin
                alu_result = sum;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_exec_pkg::reg_addr_t raddr0,
    input  rv_exec_pkg::reg_addr_t raddr1,
    output rv_exec_pkg::xlen_t     rdata0,
    output rv_exec_pkg::xlen_t     rdata1,
    input  logic                   we,
    input  rv_exec_pkg::reg_addr_t waddr,
    input  rv_exec_pkg::xlen_t     wdata
);

    import rv_exec_pkg::*;

    // x0 has no storage
    xlen_t regs [1:31];

    // All 31 registers clear on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational read with x0 tied to zero
    always_comb begin
        if (raddr0 == 5'd0) begin
            rdata0 = '0;
        end else begin
            rdata0 = regs[raddr0];
        end
    end

    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

endmodule

`default_nettype wire

/* hw/exec_core.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  rv_exec_pkg::xlen_t     instr,
    input  rv_exec_pkg::xlen_t     pc,
    output logic                   result_valid,
    output rv_exec_pkg::reg_addr_t result_rd,
    output rv_exec_pkg::xlen_t     result
);

    import rv_exec_pkg::*;

    decoded_t  dec;
    operands_t ops;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     alu_result;
    logic      issue;
    logic      rf_we;

    // Registered stage
    logic      valid_q;
    logic      wb_q;
    reg_addr_t rd_q;
    xlen_t     result_q;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr0 (dec.rs1),
        .raddr1 (dec.rs2),
        .rdata0 (rs1_data),
        .rdata1 (rs2_data),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (alu_result)
    );

    operand_select u_operand_select (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .ops      (ops)
    );

    int_alu u_alu (
        .ops        (ops),
        .alu_op     (dec.alu_op),
        .alu_result (alu_result)
    );

    // Unsupported opcodes are dropped here
    assign issue = instr_valid && (dec.op_class != cls_none);

    // Register file commits on the same edge as the result register,
    // so the next instruction reads the new value without forwarding
    assign rf_we = issue && dec.wb_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            wb_q     <= 1'b0;
            rd_q     <= '0;
            result_q <= '0;
        end else begin
            // One-cycle strobe per issued instruction
            valid_q <= issue;
            if (issue) begin
                wb_q     <= dec.wb_en;
                rd_q     <= dec.rd;
                result_q <= alu_result;
            end
        end
    end

    assign result_valid = valid_q;
    assign result       = result_q;
    // Loads and stores have no destination and show x0
    assign result_rd    = wb_q ? rd_q : '0;

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* test/tb_exec_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_exec_core;

    import rv_exec_pkg::*;

    localparam int reset_cycles = 16;

    // One line of the input file
    typedef struct packed {
        logic      issue;
        xlen_t     instr;
        xlen_t     pc;
        logic      exp_valid;
        reg_addr_t exp_rd;
        xlen_t     exp_result;
    } vector_t;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    xlen_t     instr;
    xlen_t     pc;
    logic      result_valid;
    reg_addr_t result_rd;
    xlen_t     result;

    vector_t   vec_q[$];
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    int        cycle_limit = reset_cycles + 50;

    tb_clock_gen #(.reset_cycles(reset_cycles)) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exec_core UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result       (result)
    );

    task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR at %t: %s expected %h, got %h", $realtime, name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_vectors();
        int      fd;
        int      code;
        string   line;
        xlen_t   f_issue;
        xlen_t   f_instr;
        xlen_t   f_pc;
        xlen_t   f_valid;
        xlen_t   f_rd;
        xlen_t   f_result;
        vector_t v;
        fd = $fopen("test/exec_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the input file test/exec_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Skip blank lines and column notes
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            code = $sscanf(line, "%h %h %h %h %h %h",
                           f_issue, f_instr, f_pc, f_valid, f_rd, f_result);
            if (code != 6) begin
                $display("Input line could not be parsed: %s", line);
                errors++;
                continue;
            end
            v.issue      = f_issue[0];
            v.instr      = f_instr;
            v.pc         = f_pc;
            v.exp_valid  = f_valid[0];
            v.exp_rd     = f_rd[4:0];
            v.exp_result = f_result;
            vec_q.push_back(v);
        end
        $fclose(fd);
    endtask

    // Inputs change just after the edge and the DUT samples them one edge later
    task automatic drive_vector(input vector_t v);
        instr_valid <= v.issue;
        instr       <= v.instr;
        pc          <= v.pc;
    endtask

    // Result and rd only matter when a result is expected
    task automatic check_vector(input vector_t v);
        check_value("result_valid", {31'b0, result_valid}, {31'b0, v.exp_valid});
        if (v.exp_valid) begin
            check_value("result_rd", {27'b0, result_rd}, {27'b0, v.exp_rd});
            check_value("result", result, v.exp_result);
        end
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        vector_t idle;
        $timeformat(-9, 1, " ns", 0);
        instr_valid <= 1'b0;
        instr       <= '0;
        pc          <= '0;
        idle        = '0;

        load_vectors();
        if (vec_q.size() == 0) begin
            $display("No test vectors were read from the input file");
            errors++;
        end
        cycle_limit = vec_q.size() + reset_cycles + 50;

        // Outputs idle after reset
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("result_valid", {31'b0, result_valid}, '0);
        check_value("result_rd", {27'b0, result_rd}, '0);
        check_value("result", result, '0);

        // Drive vector i and check vector i-1 at the following negedge
        for (int i = 0; i <= vec_q.size(); i++) begin
            @(posedge clk);
            if (i < vec_q.size()) begin
                drive_vector(vec_q[i]);
            end else begin
                drive_vector(idle);
            end
            @(negedge clk);
            if (i == 0) begin
                check_value("result_valid", {31'b0, result_valid}, '0);
            end else begin
                check_vector(vec_q[i-1]);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/rv_exec_pkg.sv
hw/instr_decoder.sv
hw/operand_select.sv
hw/int_alu.sv
hw/reg_file.sv
hw/exec_core.sv
test/tb_clock_gen.sv
test/tb_exec_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_exec_core \
    --Mdir obj_dir \
    -o sim_exec_core > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_exec_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* test/exec_input.txt */
# Columns in hex: instr_valid instr pc expected_result_valid expected_result_rd expected_result
# result_rd reads 00 for loads, stores and writes to x0; result is ignored when valid is 0
1 123450B7 00001000 1 01 12345000
1 00010117 00001004 1 02 00011004
1 FFB00193 00001008 1 03 FFFFFFFB
1 06400213 0000100C 1 04 00000064
1 00700013 00001010 1 00 00000007
1 004002B3 00001014 1 05 00000064
1 FFF08313 00001018 1 06 12344FFF
1 FFC1A393 0000101C 1 07 00000001
1 FFF23413 00001020 1 08 00000001
1 FFF24493 00001024 1 09 FFFFFF9B
1 F0026513 00001028 1 0A FFFFFF64
1 FF037593 0000102C 1 0B 12344FF0
1 00421613 00001030 1 0C 00000640
1 01C1D693 00001034 1 0D 0000000F
1 4011D713 00001038 1 0E FFFFFFFD
1 00D707B3 0000103C 1 0F 0000000C
1 40478833 00001040 1 10 FFFFFFA8
1 00F828B3 00001044 1 11 00000001
1 0108B933 00001048 1 12 00000001
1 012819B3 0000104C 1 13 FFFFFF50
1 4129DA33 00001050 1 14 FFFFFFA8
1 012A5AB3 00001054 1 15 7FFFFFD4
1 001ACB33 00001058 1 16 6DCBAFD4
1 004B6BB3 0000105C 1 17 6DCBAFF4
1 006BFC33 00001060 1 18 00000FF4
1 FF822C83 00001064 1 00 0000005C
1 FE122A23 00001068 1 00 00000058
1 FF825D03 0000106C 1 00 0000005C
1 000001EF 00001070 0 00 00000000
0 00100193 00001074 0 00 00000000
1 000C8DB3 00001078 1 1B 00000000
1 014D0E33 0000107C 1 1C FFFFFFA8
1 00018EB3 00001080 1 1D FFFFFFFB
